/* hdl/calc_pkg.sv */
// Widths, latencies, opcodes and packet types shared by the calculator RTL and its testbench
`default_nettype none

package calc_pkg;

  // Datapath
  localparam int DATA_W     = 32;
  localparam int REG_ADDR_W = 5;
  localparam int SHAMT_W    = $clog2(DATA_W);

  // Latencies in clock edges
  localparam int INT_LATENCY = 1;
  localparam int MUL_LATENCY = 3;
  localparam int PIPE_STAGES = 4;
  localparam int WB_LATENCY  = 5;
  localparam int FLUSH_DEPTH = 2;

  typedef enum logic [3:0]
  {
    OP_ADD,
    OP_SUB,
    OP_AND,
    OP_OR,
    OP_XOR,
    OP_SLL,
    OP_SRL,
    OP_SLT,
    OP_MUL
  } calc_op_e;

  // Operands come from a register file that may lag the pipe
  typedef struct packed
  {
    logic                  valid;
    calc_op_e              op;
    logic                  use_imm;
    logic [REG_ADDR_W-1:0] rd_addr;
    logic [REG_ADDR_W-1:0] rs1_addr;
    logic [REG_ADDR_W-1:0] rs2_addr;
    logic [DATA_W-1:0]     rs1;
    logic [DATA_W-1:0]     rs2;
    logic [DATA_W-1:0]     imm;
  } dispatch_pkt_s;

  typedef struct packed
  {
    logic                  valid;
    calc_op_e              op;
    logic [REG_ADDR_W-1:0] rd_addr;
    logic [DATA_W-1:0]     opa;
    logic [DATA_W-1:0]     opb;
    logic                  int_v;
    logic                  mul_v;
  } reservation_s;

  typedef struct packed
  {
    logic                  w_v;
    logic                  poison_v;
    logic [REG_ADDR_W-1:0] rd_addr;
    logic [DATA_W-1:0]     rd_data;
  } comp_stage_s;

  typedef struct packed
  {
    logic                  v;
    logic [REG_ADDR_W-1:0] rd_addr;
    logic [DATA_W-1:0]     data;
  } fwd_s;

  typedef struct packed
  {
    logic                  v;
    logic [REG_ADDR_W-1:0] rd_addr;
    logic [DATA_W-1:0]     rd_data;
  } wb_pkt_s;

endpackage

`default_nettype wire

/* hdl/calc_decode.sv */
// Issue stage that bypasses stale operands, resolves the immediate and loads the reservation
`timescale 1ns/1ps
`default_nettype none

module calc_decode
  import calc_pkg::*;
(
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  input  dispatch_pkt_s          dispatch_pkt_i,
  input  fwd_s [PIPE_STAGES-1:0] fwd_i,
  output reservation_s           reservation_o
);

  reservation_s      reservation_n;
  reservation_s      reservation_r;
  logic [DATA_W-1:0] bypass_rs1;
  logic [DATA_W-1:0] bypass_rs2;

  // Slice 0 is the youngest result in the completion pipe
  function automatic logic [DATA_W-1:0] bypass
  (
    input logic [REG_ADDR_W-1:0]  addr,
    input logic [DATA_W-1:0]      rf_data,
    input fwd_s [PIPE_STAGES-1:0] fwd
  );
    logic [DATA_W-1:0] data;

    data = rf_data;
    // Older slices first so a younger match overrides them
    for (int i = PIPE_STAGES - 1; i >= 0; i--)
    begin
      if (fwd[i].v && (fwd[i].rd_addr == addr))
      begin
        data = fwd[i].data;
      end
    end
    // x0 is hard-wired to zero
    if (addr == '0)
    begin
      data = '0;
    end
    return data;
  endfunction

  always_comb
  begin
    bypass_rs1 = bypass(dispatch_pkt_i.rs1_addr, dispatch_pkt_i.rs1, fwd_i);
    bypass_rs2 = bypass(dispatch_pkt_i.rs2_addr, dispatch_pkt_i.rs2, fwd_i);

    reservation_n.valid   = dispatch_pkt_i.valid;
    reservation_n.op      = dispatch_pkt_i.op;
    reservation_n.rd_addr = dispatch_pkt_i.rd_addr;
    reservation_n.opa     = bypass_rs1;
    reservation_n.opb     = dispatch_pkt_i.use_imm ? dispatch_pkt_i.imm : bypass_rs2;

    // Pipe select
    reservation_n.int_v = 1'b0;
    reservation_n.mul_v = 1'b0;
    case (dispatch_pkt_i.op)
      OP_MUL:
      begin
        reservation_n.mul_v = dispatch_pkt_i.valid;
      end
      default:
      begin
        reservation_n.int_v = dispatch_pkt_i.valid;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      reservation_r <= '0;
    end
    else
    begin
      reservation_r <= reservation_n;
    end
  end

  assign reservation_o = reservation_r;

endmodule

`default_nettype wire

/* hdl/calc_pipe_int.sv */
// Integer ALU pipe that returns its result one clock after the reservation
`timescale 1ns/1ps
`default_nettype none

module calc_pipe_int
  import calc_pkg::*;
(
  input  logic              clk_i,
  input  logic              rst_n_i,
  input  reservation_s      reservation_i,
  output logic              int_v_o,
  output logic [DATA_W-1:0] int_data_o
);

  logic [DATA_W-1:0]  alu_result;
  logic [SHAMT_W-1:0] shamt;
  logic               int_v_r;
  logic [DATA_W-1:0]  int_data_r;

  assign shamt = reservation_i.opb[SHAMT_W-1:0];

  always_comb
  begin
    case (reservation_i.op)
      OP_ADD:  alu_result = reservation_i.opa + reservation_i.opb;
      OP_SUB:  alu_result = reservation_i.opa - reservation_i.opb;
      OP_AND:  alu_result = reservation_i.opa & reservation_i.opb;
      OP_OR:   alu_result = reservation_i.opa | reservation_i.opb;
      OP_XOR:  alu_result = reservation_i.opa ^ reservation_i.opb;
      OP_SLL:  alu_result = reservation_i.opa << shamt;
      OP_SRL:  alu_result = reservation_i.opa >> shamt;
      // Signed compare
      OP_SLT:  alu_result = {{(DATA_W-1){1'b0}},
                             $signed(reservation_i.opa) < $signed(reservation_i.opb)};
      default: alu_result = '0;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      int_v_r <= 1'b0;
    end
    else
    begin
      int_v_r <= reservation_i.int_v;
    end
  end

  always_ff @(posedge clk_i)
  begin
    int_data_r <= alu_result;
  end

  assign int_v_o    = int_v_r;
  assign int_data_o = int_data_r;

endmodule

`default_nettype wire

/* hdl/calc_pipe_mul.sv */
// Pipelined multiplier returning the low product bits MUL_LATENCY clocks after the reservation
`timescale 1ns/1ps
`default_nettype none

module calc_pipe_mul
  import calc_pkg::*;
(
  input  logic              clk_i,
  input  logic              rst_n_i,
  input  reservation_s      reservation_i,
  output logic              mul_v_o,
  output logic [DATA_W-1:0] mul_data_o
);

  logic [DATA_W-1:0]                  product;
  logic [MUL_LATENCY-1:0]             mul_v_r;
  logic [MUL_LATENCY-1:0][DATA_W-1:0] mul_data_r;

  // Only the low half of the product is kept
  assign product = reservation_i.opa * reservation_i.opb;

  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      mul_v_r <= '0;
    end
    else
    begin
      mul_v_r <= {mul_v_r[MUL_LATENCY-2:0], reservation_i.mul_v};
    end
  end

  // Each stage loads only when a valid item moves into it
  always_ff @(posedge clk_i)
  begin
    if (reservation_i.mul_v)
    begin
      mul_data_r[0] <= product;
    end
    for (int i = 1; i < MUL_LATENCY; i++)
    begin
      if (mul_v_r[i-1])
      begin
        mul_data_r[i] <= mul_data_r[i-1];
      end
    end
  end

  assign mul_v_o    = mul_v_r[MUL_LATENCY-1];
  assign mul_data_o = mul_data_r[MUL_LATENCY-1];

endmodule

`default_nettype wire

/* hdl/calc_result.sv */
// Completion pipe that merges pipe results, tracks flush poison and drives forwarding and writeback
`timescale 1ns/1ps
`default_nettype none

module calc_result
  import calc_pkg::*;
(
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  input  logic                   flush_i,
  input  reservation_s           reservation_i,
  input  logic                   int_v_i,
  input  logic [DATA_W-1:0]      int_data_i,
  input  logic                   mul_v_i,
  input  logic [DATA_W-1:0]      mul_data_i,
  output fwd_s [PIPE_STAGES-1:0] fwd_o,
  output wb_pkt_s                wb_pkt_o
);

  // Entry PIPE_STAGES is the writeback register
  comp_stage_s [PIPE_STAGES:0] comp_stage_n;
  comp_stage_s [PIPE_STAGES:0] comp_stage_r;
  logic                        flush_r;

  always_comb
  begin
    // New entry from the reservation register
    comp_stage_n[0].w_v      = reservation_i.valid;
    comp_stage_n[0].poison_v = 1'b0;
    comp_stage_n[0].rd_addr  = reservation_i.rd_addr;
    comp_stage_n[0].rd_data  = '0;

    for (int i = 1; i <= PIPE_STAGES; i++)
    begin
      comp_stage_n[i] = comp_stage_r[i-1];
    end

    // Single issue with static latencies, so at most one pipe lands per stage
    if (int_v_i)
    begin
      comp_stage_n[INT_LATENCY].rd_data |= int_data_i;
    end
    if (mul_v_i)
    begin
      comp_stage_n[MUL_LATENCY].rd_data |= mul_data_i;
    end

    // The packet sampled on the flush edge is still in decode, so its poison lags one clock
    comp_stage_n[0].poison_v |= flush_r;
    for (int i = 0; i < FLUSH_DEPTH; i++)
    begin
      comp_stage_n[i].poison_v |= flush_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      comp_stage_r <= '0;
      flush_r      <= 1'b0;
    end
    else
    begin
      comp_stage_r <= comp_stage_n;
      flush_r      <= flush_i;
    end
  end

  // Forwarding slices ordered youngest first
  always_comb
  begin
    for (int i = 1; i <= PIPE_STAGES; i++)
    begin
      fwd_o[i-1].v       = comp_stage_n[i].w_v & ~comp_stage_n[i].poison_v;
      fwd_o[i-1].rd_addr = comp_stage_n[i].rd_addr;
      fwd_o[i-1].data    = comp_stage_n[i].rd_data;
    end
  end

  assign wb_pkt_o = '{
    v:       comp_stage_r[PIPE_STAGES].w_v & ~comp_stage_r[PIPE_STAGES].poison_v,
    rd_addr: comp_stage_r[PIPE_STAGES].rd_addr,
    rd_data: comp_stage_r[PIPE_STAGES].rd_data
  };

endmodule

`default_nettype wire

/* hdl/calc_top.sv */
// Calculator top connecting decode, the integer and multiply pipes and the completion pipe
`timescale 1ns/1ps
`default_nettype none

module calc_top
  import calc_pkg::*;
(
  input  logic          clk_i,
  input  logic          rst_n_i,
  input  dispatch_pkt_s dispatch_pkt_i,
  input  logic          flush_i,
  output wb_pkt_s       wb_pkt_o
);

  reservation_s           reservation;
  fwd_s [PIPE_STAGES-1:0] fwd;
  logic                   int_v;
  logic [DATA_W-1:0]      int_data;
  logic                   mul_v;
  logic [DATA_W-1:0]      mul_data;

  calc_decode u_decode
  (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .dispatch_pkt_i (dispatch_pkt_i),
    .fwd_i          (fwd),
    .reservation_o  (reservation)
  );

  // Execute pipes
  calc_pipe_int u_pipe_int
  (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .reservation_i (reservation),
    .int_v_o       (int_v),
    .int_data_o    (int_data)
  );

  calc_pipe_mul u_pipe_mul
  (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .reservation_i (reservation),
    .mul_v_o       (mul_v),
    .mul_data_o    (mul_data)
  );

  calc_result u_result
  (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .flush_i       (flush_i),
    .reservation_i (reservation),
    .int_v_i       (int_v),
    .int_data_i    (int_data),
    .mul_v_i       (mul_v),
    .mul_data_i    (mul_data),
    .fwd_o         (fwd),
    .wb_pkt_o      (wb_pkt_o)
  );

endmodule

`default_nettype wire

/* sim/tb_calc_model.svh */
// Reference model for the calculator testbench, included inside the testbench module body
`ifndef TB_CALC_MODEL_SVH
`define TB_CALC_MODEL_SVH

typedef struct packed
{
  int                    tag;
  logic [REG_ADDR_W-1:0] rd_addr;
  logic [DATA_W-1:0]     rd_data;
  logic [DATA_W-1:0]     prev_data;
} exp_wb_s;

// Architectural file holds ideal results, committed file follows observed writebacks
logic [DATA_W-1:0] arch_rf [2**REG_ADDR_W];
logic [DATA_W-1:0] comm_rf [2**REG_ADDR_W];
exp_wb_s           exp_q [$];

function automatic logic [DATA_W-1:0] ideal_result
(
  input calc_op_e          op,
  input logic [DATA_W-1:0] a,
  input logic [DATA_W-1:0] b
);
  case (op)
    OP_ADD:  return a + b;
    OP_SUB:  return a - b;
    OP_AND:  return a & b;
    OP_OR:   return a | b;
    OP_XOR:  return a ^ b;
    OP_SLL:  return a << b[4:0];
    OP_SRL:  return a >> b[4:0];
    OP_SLT:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
    OP_MUL:  return a * b;
    default: return '0;
  endcase
endfunction

function automatic logic [DATA_W-1:0] arch_read(input logic [REG_ADDR_W-1:0] addr);
  return (addr == '0) ? '0 : arch_rf[addr];
endfunction

task automatic record_dispatch
(
  input int                    tag,
  input logic [REG_ADDR_W-1:0] rd,
  input logic [DATA_W-1:0]     data
);
  exp_wb_s e;

  e.tag       = tag;
  e.rd_addr   = rd;
  e.rd_data   = data;
  e.prev_data = arch_rf[rd];
  exp_q.push_back(e);
  if (rd != '0)
  begin
    arch_rf[rd] = data;
  end
endtask

// Youngest entries go first so the older value is restored last
task automatic drop_flushed(input int oldest_tag);
  exp_wb_s e;

  while (exp_q.size() > 0 && exp_q[$].tag >= oldest_tag)
  begin
    e = exp_q.pop_back();
    if (e.rd_addr != '0)
    begin
      arch_rf[e.rd_addr] = e.prev_data;
    end
  end
endtask

task automatic commit_writeback(input logic [REG_ADDR_W-1:0] rd, input logic [DATA_W-1:0] data);
  if (rd != '0)
  begin
    comm_rf[rd] = data;
  end
endtask

`endif

/* sim/tb_calc.sv */
// Testbench for calc_top with random and directed dispatch, flushes and a reference model check
`timescale 1ns/1ps
`default_nettype none

module tb_calc
  import calc_pkg::*;
();

  localparam int RESET_CYCLES   = 16;
  localparam int N_IDLE         = 4;
  localparam int N_INT          = 160;
  localparam int N_CHAIN        = 28;
  localparam int N_MUL          = 8;
  localparam int N_FLUSH        = 5;
  localparam int N_MIX          = 200;
  localparam int TOTAL_DISPATCH = N_IDLE + N_INT + N_CHAIN + N_MUL + N_FLUSH + N_MIX;
  localparam int TIMEOUT_CYCLES = RESET_CYCLES + TOTAL_DISPATCH + WB_LATENCY + 20;
  // Dispatch edges until a result reaches a reader through bypass or register file
  localparam int INT_READ_GAP = 2;
  localparam int MUL_READ_GAP = 4;

  logic          clk_i;
  logic          rst_n_i;
  dispatch_pkt_s dispatch_pkt_i;
  logic          flush_i;
  wb_pkt_s       wb_pkt_o;

  int   seed;
  int   edge_cnt;
  int   cycle_cnt = 0;
  int   last_wr [2**REG_ADDR_W];
  logic last_mul [2**REG_ADDR_W];

  `include "tb_calc_model.svh"

  calc_top DUT
  (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .dispatch_pkt_i (dispatch_pkt_i),
    .flush_i        (flush_i),
    .wb_pkt_o       (wb_pkt_o)
  );

  always #50 clk_i = ~clk_i;

  always @(posedge clk_i)
  begin
    cycle_cnt++;
    if (cycle_cnt > TIMEOUT_CYCLES)
    begin
      $display("timeout: the run did not end within %0d cycles", TIMEOUT_CYCLES);
      $display("Testbench failed");
      $fatal(1);
    end
  end

  task automatic report_error(input string msg);
    $display("error at %0t ns: %s", $time, msg);
    $display("Testbench failed");
    $fatal(1);
  endtask

  task automatic check_writeback();
    exp_wb_s e;

    if (exp_q.size() > 0 && exp_q[0].tag == edge_cnt - WB_LATENCY)
    begin
      e = exp_q.pop_front();
      assert (wb_pkt_o.v && wb_pkt_o.rd_addr == e.rd_addr && wb_pkt_o.rd_data == e.rd_data)
      else report_error($sformatf("writeback v=%0b x%0d=%h, expected x%0d=%h",
                                  wb_pkt_o.v, wb_pkt_o.rd_addr, wb_pkt_o.rd_data,
                                  e.rd_addr, e.rd_data));
      commit_writeback(wb_pkt_o.rd_addr, wb_pkt_o.rd_data);
    end
    else
    begin
      assert (!wb_pkt_o.v)
      else report_error($sformatf("unexpected writeback to x%0d", wb_pkt_o.rd_addr));
    end
  endtask

  // Outputs are registered, so they are stable 1 ns after the edge
  task automatic advance_cycle();
    @(posedge clk_i);
    edge_cnt++;
    #1;
    check_writeback();
  endtask

  task automatic drive_packet
  (
    input logic                  valid,
    input calc_op_e              op,
    input logic                  use_imm,
    input logic [REG_ADDR_W-1:0] rd,
    input logic [REG_ADDR_W-1:0] rs1_a,
    input logic [REG_ADDR_W-1:0] rs2_a,
    input logic [DATA_W-1:0]     imm,
    input logic                  flush
  );
    dispatch_pkt_s     pkt;
    int                tag;
    logic [DATA_W-1:0] opb;

    tag          = edge_cnt + 1;
    pkt.valid    = valid;
    pkt.op       = op;
    pkt.use_imm  = use_imm;
    pkt.rd_addr  = rd;
    pkt.rs1_addr = rs1_a;
    pkt.rs2_addr = rs2_a;
    pkt.rs1      = comm_rf[rs1_a];
    pkt.rs2      = comm_rf[rs2_a];
    pkt.imm      = imm;
    dispatch_pkt_i = pkt;
    flush_i        = flush;
    if (valid)
    begin
      opb = use_imm ? imm : arch_read(rs2_a);
      record_dispatch(tag, rd, ideal_result(op, arch_read(rs1_a), opb));
      last_wr[rd]  = tag;
      last_mul[rd] = (op == OP_MUL);
    end
    if (flush)
    begin
      drop_flushed(tag - FLUSH_DEPTH);
    end
  endtask

  task automatic issue
  (
    input calc_op_e              op,
    input logic                  use_imm,
    input logic [REG_ADDR_W-1:0] rd,
    input logic [REG_ADDR_W-1:0] rs1_a,
    input logic [REG_ADDR_W-1:0] rs2_a,
    input logic [DATA_W-1:0]     imm,
    input logic                  flush
  );
    advance_cycle();
    drive_packet(1'b1, op, use_imm, rd, rs1_a, rs2_a, imm, flush);
  endtask

  task automatic issue_bubble();
    advance_cycle();
    drive_packet(1'b0, OP_ADD, 1'b0, '0, '0, '0, '0, 1'b0);
  endtask

  // Avoids registers whose latest writer cannot reach the reader yet
  function automatic logic [REG_ADDR_W-1:0] pick_source(input int tag);
    logic [31:0]           rnd;
    logic [REG_ADDR_W-1:0] r;

    for (int n = 0; n < 8; n++)
    begin
      rnd = $random(seed);
      r   = rnd[REG_ADDR_W-1:0];
      if (r == '0 || tag - last_wr[r] >= (last_mul[r] ? MUL_READ_GAP : INT_READ_GAP))
      begin
        return r;
      end
    end
    return '0;
  endfunction

  task automatic issue_random(input logic allow_mul, input logic allow_flush);
    logic [31:0]           rnd;
    logic                  valid;
    calc_op_e              op;
    logic                  use_imm;
    logic                  flush;
    logic [REG_ADDR_W-1:0] rd;
    logic [REG_ADDR_W-1:0] rs1_a;
    logic [REG_ADDR_W-1:0] rs2_a;

    advance_cycle();
    rnd     = $random(seed);
    valid   = (rnd[2:0] != 3'd0);
    op      = calc_op_e'({1'b0, rnd[5:3]});
    if (allow_mul && rnd[7:6] == 2'd0)
    begin
      op = OP_MUL;
    end
    use_imm = rnd[8] && (op != OP_MUL);
    flush   = allow_flush && (rnd[12:9] == 4'd0);
    rd      = rnd[17:13];
    rs1_a   = pick_source(edge_cnt + 1);
    rs2_a   = pick_source(edge_cnt + 1);
    drive_packet(valid, op, use_imm, rd, rs1_a, rs2_a, $random(seed), flush);
  endtask

  function automatic logic [REG_ADDR_W-1:0] chain_reg(input int i);
    return (i % 6 == 5) ? '0 : REG_ADDR_W'(8 + i % 6);
  endfunction

  initial
  begin
    clk_i          = 1'b0;
    rst_n_i        = 1'b0;
    dispatch_pkt_i = '0;
    flush_i        = 1'b0;
    seed           = 45;
    edge_cnt       = 0;
    for (int r = 0; r < 2**REG_ADDR_W; r++)
    begin
      arch_rf[r]  = '0;
      comm_rf[r]  = '0;
      last_wr[r]  = -100;
      last_mul[r] = 1'b0;
    end
    repeat (RESET_CYCLES) advance_cycle();
    rst_n_i = 1'b1;

    repeat (N_IDLE) issue_bubble();
    repeat (N_INT) issue_random(1'b0, 1'b0);

    // Dependent chain at the shortest integer distance with every sixth result going to x0
    repeat (4) issue_bubble();
    for (int i = 0; i < N_CHAIN - 4; i++)
    begin
      issue(calc_op_e'(i % 8), (i % 5 == 4), chain_reg(i),
            (i >= 2) ? chain_reg(i - 2) : '0, (i >= 3) ? chain_reg(i - 3) : '0,
            DATA_W'(i * 3 + 1), 1'b0);
    end

    // Three muls in flight with consumers at the mul read distance
    issue(OP_MUL, 1'b0, 5'd20, 5'd8, 5'd9, '0, 1'b0);
    issue(OP_MUL, 1'b0, 5'd21, 5'd10, 5'd11, '0, 1'b0);
    issue(OP_MUL, 1'b0, 5'd22, 5'd12, 5'd8, '0, 1'b0);
    issue_bubble();
    issue(OP_ADD, 1'b0, 5'd23, 5'd20, 5'd0, '0, 1'b0);
    issue(OP_XOR, 1'b0, 5'd24, 5'd21, 5'd20, '0, 1'b0);
    issue(OP_SUB, 1'b0, 5'd25, 5'd22, 5'd21, '0, 1'b0);
    issue_bubble();

    // Flush on the last packet leaves only the first one
    issue(OP_ADD, 1'b1, 5'd26, 5'd20, 5'd0, 32'h11, 1'b0);
    issue(OP_ADD, 1'b1, 5'd27, 5'd21, 5'd0, 32'h22, 1'b0);
    issue(OP_OR, 1'b1, 5'd26, 5'd22, 5'd0, 32'h33, 1'b0);
    issue(OP_AND, 1'b0, 5'd24, 5'd23, 5'd25, '0, 1'b1);
    // Reader of the flushed destinations must see the older values
    issue(OP_ADD, 1'b0, 5'd28, 5'd26, 5'd27, '0, 1'b0);

    repeat (N_MIX) issue_random(1'b1, 1'b1);

    while (exp_q.size() != 0)
    begin
      issue_bubble();
    end
    repeat (2) issue_bubble();

    $display("Testbench passed");
    $finish;
  end

endmodule

`default_nettype wire

/* tb.f */
+incdir+sim
hdl/calc_pkg.sv
hdl/calc_decode.sv
hdl/calc_pipe_int.sv
hdl/calc_pipe_mul.sv
hdl/calc_result.sv
hdl/calc_top.sv
sim/tb_calc.sv

/* Bender.yml */
package:
  name: calc

sources:
  - hdl/calc_pkg.sv
  - hdl/calc_decode.sv
  - hdl/calc_pipe_int.sv
  - hdl/calc_pipe_mul.sv
  - hdl/calc_result.sv
  - hdl/calc_top.sv
  - target: simulation
    include_dirs:
      - sim
    files:
      - sim/tb_calc.sv
